// File: design/mem_pkg.sv
// widths, opcode and response enums, and the pipeline stage structs
package mem_pkg;

   localparam int ADDR_W      = 32;
   localparam int DATA_W      = 128;
   localparam int STRB_W      = DATA_W / 8;             // one strobe per byte
   localparam int ID_W        = 4;
   localparam int BRAM_ADDR_W = 14;                     // 16 KB window
   localparam int LINE_OFFSET = $clog2(STRB_W);
   localparam int LINE_IDX_W  = BRAM_ADDR_W - LINE_OFFSET;
   localparam int BRAM_LINES  = 2 ** LINE_IDX_W;

   typedef enum logic {
      op_read  = 1'b0,
      op_write = 1'b1
   } mem_op_e;

   // AXI response encoding
   typedef enum logic [1:0] {
      resp_okay   = 2'b00,
      resp_decerr = 2'b11
   } mem_resp_e;

   // request as seen on the core side
   typedef struct packed {
      mem_op_e             op;
      logic [ID_W-1:0]     id;
      logic [ADDR_W-1:0]   addr;
      logic [STRB_W-1:0]   strb;
      logic [DATA_W-1:0]   wdata;
   } mem_req_t;

   // decode to ram, address already reduced to a line index
   typedef struct packed {
      mem_op_e               op;
      logic [ID_W-1:0]       id;
      logic                  hit;
      logic [LINE_IDX_W-1:0] line_idx;
      logic [STRB_W-1:0]     strb;
      logic [DATA_W-1:0]     wdata;
   } dec_stage_t;

   // ram to response build, read data travels beside it
   typedef struct packed {
      mem_op_e           op;
      logic [ID_W-1:0]   id;
      logic              hit;
   } ram_stage_t;

   typedef struct packed {
      logic [ID_W-1:0]   id;
      mem_resp_e         resp;
      logic [DATA_W-1:0] rdata;
   } mem_rsp_t;

endpackage

// File: design/req_decode.sv
// request register stage with block RAM window decode
module req_decode (
   input  logic                 mig_clk,
   input  logic                 arst_n_i,
   input  logic                 req_valid_i,
   input  mem_pkg::mem_req_t    req_i,
   output logic                 dec_valid_o,
   output mem_pkg::dec_stage_t  dec_o
);

   import mem_pkg::*;

   logic                  win_hit;
   logic [LINE_IDX_W-1:0] win_idx;

   // everything above the 16 KB window must be zero
   assign win_hit = (req_i.addr[ADDR_W-1:BRAM_ADDR_W] == '0);
   assign win_idx = req_i.addr[BRAM_ADDR_W-1:LINE_OFFSET];   // byte offset dropped

   always_ff @(posedge mig_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         dec_valid_o <= 1'b0;
      end else begin
         dec_valid_o <= req_valid_i;
      end
   end

   // payload only moves with a valid request
   always_ff @(posedge mig_clk) begin
      if (req_valid_i) begin
         dec_o.op       <= req_i.op;
         dec_o.id       <= req_i.id;
         dec_o.hit      <= win_hit;
         dec_o.line_idx <= win_idx;
         dec_o.strb     <= req_i.strb;
         dec_o.wdata    <= req_i.wdata;
      end
   end

   // the strobe drives the whole pipeline, an X here would poison every stage
   a_req_valid_known : assert property (
      @(posedge mig_clk) disable iff (!arst_n_i)
      !$isunknown(req_valid_i)
   ) else $error("req_valid_i unknown out of reset");

endmodule

// File: design/bram_bank.sv
// byte-strobed line memory with registered read index and metadata forwarding
module bram_bank (
   input  logic                       mig_clk,
   input  logic                       arst_n_i,
   input  logic                       dec_valid_i,
   input  mem_pkg::dec_stage_t        dec_i,
   output logic                       ram_valid_o,
   output mem_pkg::ram_stage_t        ram_o,
   output logic [mem_pkg::DATA_W-1:0] rdata_o
);

   import mem_pkg::*;

   logic [DATA_W-1:0]     mem [BRAM_LINES];
   logic [LINE_IDX_W-1:0] rd_idx;
   logic [STRB_W-1:0]     byte_we;
   logic                  wr_en;

   // misses and reads never touch the array
   assign wr_en   = dec_valid_i && dec_i.hit && (dec_i.op == op_write);
   assign byte_we = wr_en ? dec_i.strb : '0;

   always_ff @(posedge mig_clk) begin
      for (int b = 0; b < STRB_W; b++) begin
         if (byte_we[b]) begin
            mem[dec_i.line_idx][b*8 +: 8] <= dec_i.wdata[b*8 +: 8];
         end
      end
   end

   always_ff @(posedge mig_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ram_valid_o <= 1'b0;
      end else begin
         ram_valid_o <= dec_valid_i;
      end
   end

   // read index registered like an inferred block RAM
   always_ff @(posedge mig_clk) begin
      if (dec_valid_i) begin
         rd_idx    <= dec_i.line_idx;
         ram_o.op  <= dec_i.op;
         ram_o.id  <= dec_i.id;
         ram_o.hit <= dec_i.hit;
      end
   end

   assign rdata_o = mem[rd_idx];   // sees a write from the edge before

   // no write and the same read index leave the line on rdata_o untouched
   a_no_stray_write : assert property (
      @(posedge mig_clk) disable iff (!arst_n_i)
      (!wr_en && (!dec_valid_i || (dec_i.line_idx == rd_idx)) && !$isunknown(rd_idx))
         |=> $stable(rdata_o)
   ) else $error("line changed without a valid hit write");

endmodule

// File: design/resp_build.sv
// response code and read data select, registered response output
module resp_build (
   input  logic                       mig_clk,
   input  logic                       arst_n_i,
   input  logic                       ram_valid_i,
   input  mem_pkg::ram_stage_t        ram_i,
   input  logic [mem_pkg::DATA_W-1:0] rdata_i,
   output logic                       rsp_valid_o,
   output mem_pkg::mem_rsp_t          rsp_o
);

   import mem_pkg::*;

   mem_resp_e         resp_code;
   logic [DATA_W-1:0] resp_data;

   assign resp_code = ram_i.hit ? resp_okay : resp_decerr;
   // only a hit read carries the line
   assign resp_data = (ram_i.hit && (ram_i.op == op_read)) ? rdata_i : '0;

   always_ff @(posedge mig_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rsp_valid_o <= 1'b0;
      end else begin
         rsp_valid_o <= ram_valid_i;
      end
   end

   always_ff @(posedge mig_clk) begin
      if (ram_valid_i) begin
         rsp_o.id    <= ram_i.id;
         rsp_o.resp  <= resp_code;
         rsp_o.rdata <= resp_data;
      end
   end

   a_decerr_no_data : assert property (
      @(posedge mig_clk) disable iff (!arst_n_i)
      (rsp_valid_o && (rsp_o.resp == resp_decerr)) |-> (rsp_o.rdata == '0)
   ) else $error("decode error response with data");

endmodule

// File: design/mem_subsys_top.sv
// cached-memory path top, decode then block RAM then response
module mem_subsys_top (
   input  logic               mig_clk,
   input  logic               arst_n_i,
   input  logic               req_valid_i,
   input  mem_pkg::mem_req_t  req_i,
   output logic               rsp_valid_o,
   output mem_pkg::mem_rsp_t  rsp_o
);

   import mem_pkg::*;

   logic              dec_valid;
   dec_stage_t        dec;
   logic              ram_valid;
   ram_stage_t        ram;
   logic [DATA_W-1:0] ram_rdata;

   req_decode u_req_decode (
      .mig_clk     (mig_clk),
      .arst_n_i    (arst_n_i),
      .req_valid_i (req_valid_i),
      .req_i       (req_i),
      .dec_valid_o (dec_valid),
      .dec_o       (dec)
   );

   bram_bank u_bram_bank (
      .mig_clk     (mig_clk),
      .arst_n_i    (arst_n_i),
      .dec_valid_i (dec_valid),
      .dec_i       (dec),
      .ram_valid_o (ram_valid),
      .ram_o       (ram),
      .rdata_o     (ram_rdata)
   );

   resp_build u_resp_build (
      .mig_clk     (mig_clk),
      .arst_n_i    (arst_n_i),
      .ram_valid_i (ram_valid),
      .ram_i       (ram),
      .rdata_i     (ram_rdata),
      .rsp_valid_o (rsp_valid_o),
      .rsp_o       (rsp_o)
   );

endmodule

// File: include/tb_checks.svh
// response field compare task and error counters for the testbench
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int unsigned mismatch_cnt = 0;   // failed field compares
int unsigned order_cnt    = 0;   // unexpected or missing responses

// compare one response field, values shown in hex
task automatic check_field(
   input string                      name,
   input logic [mem_pkg::DATA_W-1:0] got,
   input logic [mem_pkg::DATA_W-1:0] exp
);
   if (got !== exp) begin
      mismatch_cnt++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
   end
endtask

// protocol trouble, stated in words
task automatic report_order(input string msg);
   order_cnt++;
   $display("[FAIL] %s", msg);
endtask

function automatic int unsigned total_errors();
   return mismatch_cnt + order_cnt;
endfunction

`endif

// File: tests/tb_mem_subsys.sv
// testbench for the memory subsystem: clock, reset, data file stimulus, response checks, watchdog
module tb_mem_subsys;

   import mem_pkg::*;

   localparam int NUM_ENTRIES     = 36;
   localparam int WORDS_PER_ENTRY = 8;   // op id addr strb wdata resp rdata b2b
   localparam int RESET_CYCLES    = 8;
   localparam int TIMEOUT_CYCLES  = NUM_ENTRIES * 4 + 3 + 20;

   typedef struct packed {
      mem_rsp_t    rsp;
      logic [31:0] sample_edge;   // edge where the DUT samples the request
   } expect_t;

   logic     mig_clk;
   logic     arst_n_i;
   logic     req_valid_i;
   mem_req_t req_i;
   logic     rsp_valid_o;
   mem_rsp_t rsp_o;

   logic [DATA_W-1:0] raw [NUM_ENTRIES * WORDS_PER_ENTRY];
   expect_t           exp_q [$];
   expect_t           front_exp;
   int unsigned       edge_cnt = 0;
   integer            seed     = 32'hfce2;

   `include "tb_checks.svh"

   mem_subsys_top dut0 (
      .mig_clk     (mig_clk),
      .arst_n_i    (arst_n_i),
      .req_valid_i (req_valid_i),
      .req_i       (req_i),
      .rsp_valid_o (rsp_valid_o),
      .rsp_o       (rsp_o)
   );

   initial begin
      mig_clk = 1'b0;
      forever #50 mig_clk = ~mig_clk;
   end

   always @(posedge mig_clk) edge_cnt <= edge_cnt + 1;

   // one request from the table on the next rising edge
   task automatic send_entry(input int unsigned n);
      int unsigned base;
      mem_req_t    req;
      expect_t     want;
      base          = n * WORDS_PER_ENTRY;
      req.op        = mem_op_e'(raw[base][0]);
      req.id        = raw[base + 1][ID_W-1:0];
      req.addr      = raw[base + 2][ADDR_W-1:0];
      req.strb      = raw[base + 3][STRB_W-1:0];
      req.wdata     = raw[base + 4];
      want.rsp.id   = req.id;
      want.rsp.resp = mem_resp_e'(raw[base + 5][1:0]);
      want.rsp.rdata = raw[base + 6];
      @(posedge mig_clk);
      req_valid_i <= 1'b1;
      req_i       <= req;
      want.sample_edge = edge_cnt + 2;   // this edge is edge_cnt+1
      exp_q.push_back(want);
   endtask

   task automatic idle_cycles(input int unsigned count);
      repeat (count) begin
         @(posedge mig_clk);
         req_valid_i <= 1'b0;
      end
   endtask

   task automatic finish_run();
      if (exp_q.size() != 0) begin
         report_order($sformatf("%0d responses never arrived", exp_q.size()));
      end
      $display("errors: %0d field mismatches, %0d order or protocol errors",
               mismatch_cnt, order_cnt);
      if (total_errors() == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   endtask

   // stimulus
   initial begin
      int unsigned gap;
      arst_n_i    = 1'b0;
      req_valid_i = 1'b0;
      req_i       = '0;
      $readmemh("tests/mem_testdata.hex", raw);
      if ($isunknown(raw[NUM_ENTRIES * WORDS_PER_ENTRY - 1])) begin
         report_order("test data file holds fewer entries than expected");
      end
      repeat (RESET_CYCLES) @(posedge mig_clk);
      arst_n_i <= 1'b1;
      for (int n = 0; n < NUM_ENTRIES; n++) begin
         if (raw[n * WORDS_PER_ENTRY + 7][0] == 1'b0) begin
            gap = $unsigned($random(seed)) % 4;
            idle_cycles(gap);
         end
         send_entry(n);
      end
      idle_cycles(1);
      while (exp_q.size() != 0) @(negedge mig_clk);
      repeat (4) @(negedge mig_clk);   // catch stray responses
      finish_run();
   end

   // response monitor, sampled mid-cycle
   always @(negedge mig_clk) begin
      if (!arst_n_i) begin
         if (rsp_valid_o !== 1'b0) begin
            report_order("rsp_valid_o not low during reset");
         end
      end else if (rsp_valid_o === 1'b1) begin
         if (exp_q.size() == 0) begin
            report_order("response seen with no request outstanding");
         end else begin
            front_exp = exp_q.pop_front();
            check_field("rsp_o.id", DATA_W'(rsp_o.id), DATA_W'(front_exp.rsp.id));
            check_field("rsp_o.resp", DATA_W'(rsp_o.resp), DATA_W'(front_exp.rsp.resp));
            check_field("rsp_o.rdata", rsp_o.rdata, front_exp.rsp.rdata);
            // valid in the cycle after edge E+2
            check_field("rsp_valid_o edge", DATA_W'(edge_cnt),
                        DATA_W'(front_exp.sample_edge + 32'd2));
         end
      end else if (rsp_valid_o !== 1'b0) begin
         report_order("rsp_valid_o unknown after reset");
      end
   end

   initial begin : watchdog
      while (edge_cnt < RESET_CYCLES + TIMEOUT_CYCLES) @(negedge mig_clk);
      report_order($sformatf("timeout, run did not end within %0d cycles", TIMEOUT_CYCLES));
      finish_run();
   end

endmodule

// File: tests/mem_testdata.hex
// columns: op(1=write) id addr strb wdata expected_resp(0=okay 3=decerr) expected_rdata
// last column 1 = send on the edge right after the previous request
1 1 00000000 ffff 00112233445566778899aabbccddeeff 0 0 0
1 2 00000010 ffff 0f1e2d3c4b5a69788796a5b4c3d2e1f0 0 0 0
1 3 00003ff0 ffff deadbeefcafef00d0123456789abcdef 0 0 0
1 4 00001550 ffff 55555555aaaaaaaa55555555aaaaaaaa 0 0 0
0 5 00000000 0000 0 0 00112233445566778899aabbccddeeff 0
0 6 00000018 0000 0 0 0f1e2d3c4b5a69788796a5b4c3d2e1f0 0
0 7 00003ffc 0000 0 0 deadbeefcafef00d0123456789abcdef 0
0 8 00001550 0000 0 0 55555555aaaaaaaa55555555aaaaaaaa 0
1 9 00000010 000f 11111111111111111111111111111111 0 0 0
1 a 00000010 f000 22222222222222222222222222222222 0 0 0
0 b 00000010 0000 0 0 222222224b5a69788796a5b411111111 0
1 c 00001550 5555 0123456789abcdeffedcba9876543210 0 0 0
0 d 00001550 0000 0 0 55235567aaabaaef55dc5598aa54aa10 0
1 e 00003ff0 0000 ffffffffffffffffffffffffffffffff 0 0 0
0 f 00003ff0 0000 0 0 deadbeefcafef00d0123456789abcdef 0
1 0 00004000 ffff 99999999999999999999999999999999 3 0 0
0 1 80000010 0000 0 3 0 0
1 2 00014010 ffff aaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaa 3 0 0
0 3 00000000 0000 0 0 00112233445566778899aabbccddeeff 0
0 4 00000010 0000 0 0 222222224b5a69788796a5b411111111 0
0 5 ffffffff 0000 0 3 0 0
1 6 00000020 ffff 0123456789abcdef0011223344556677 0 0 0
0 7 00000020 0000 0 0 0123456789abcdef0011223344556677 1
1 8 00000020 00ff ffffffffffffffffffffffffffffffff 0 0 1
0 9 00000024 0000 0 0 0123456789abcdefffffffffffffffff 1
1 a 00000030 ffff cccccccccccccccccccccccccccccccc 0 0 1
1 b 00000030 8001 00000000000000000000000000000000 0 0 1
0 c 00000030 0000 0 0 00cccccccccccccccccccccccccccc00 1
0 d 00004030 0000 0 3 0 1
0 e 00000000 0000 0 0 00112233445566778899aabbccddeeff 1
1 f 00003ff0 ffff 00000000000000000000000000000001 0 0 1
0 0 00003ff8 0000 0 0 00000000000000000000000000000001 1
0 1 00000020 0000 0 0 0123456789abcdefffffffffffffffff 0
0 2 00001550 0000 0 0 55235567aaabaaef55dc5598aa54aa10 0
1 3 00002a00 ffff 13579bdf2468ace0fedcba9876543210 0 0 0
0 4 00002a0f 0000 0 0 13579bdf2468ace0fedcba9876543210 1

// File: flist.f
+incdir+include
design/mem_pkg.sv
design/req_decode.sv
design/bram_bank.sv
design/resp_build.sv
design/mem_subsys_top.sv
tests/tb_mem_subsys.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --timing --assert
TOP      := tb_mem_subsys
FLIST    := flist.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD) -o sim_$(TOP)
	./$(BUILD)/sim_$(TOP) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
